// ==== dv/rv_ref_model.sv ====
// ==================================================
// Instruction-level RV32I reference model
// Steps the program image once per retire and
// presents the expected retire record
// ==================================================

`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module rv_ref_model import rv_pkg::*; (
	input  wire         clk,
	input  wire         rst_n,
	input  wire         step_i,
	input  logic [31:0] mem_i [0:(1 << (`RV_IMEM_AW - 2)) - 1],
	output retire_t     exp_o
);

	logic [31:0] pc_q;
	logic [31:0] regs_q [0:`RV_NREGS-1];
	logic [31:0] word;
	logic [6:0]  op;
	logic [6:0]  f7;
	logic [2:0]  f3;
	logic [4:0]  rd;
	logic [31:0] src1;
	logic [31:0] src2;
	logic [31:0] imm_i;
	logic [31:0] imm_b;
	logic [31:0] imm_j;
	logic [31:0] res;
	logic [31:0] nxt;
	logic        wr;
	logic        ill;
	logic        tk;

	// ISA semantics of the integer ALU groups, alt picks SUB and SRA
	function automatic logic [31:0] alu_ref(input logic [2:0] fn, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (fn)
			3'd0:    alu_ref = alt ? a - b : a + b;
			3'd1:    alu_ref = a << b[4:0];
			3'd2:    alu_ref = {31'd0, $signed(a) < $signed(b)};
			3'd3:    alu_ref = {31'd0, a < b};
			3'd4:    alu_ref = a ^ b;
			3'd5:    alu_ref = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6:    alu_ref = a | b;
			default: alu_ref = a & b;
		endcase
	endfunction

	// ==================================================
	// Next step from the current architectural state
	// ==================================================
	always_comb begin
		word  = mem_i[pc_q[`RV_IMEM_AW-1:2]];
		op    = word[6:0];
		rd    = word[11:7];
		f3    = word[14:12];
		f7    = word[31:25];
		src1  = regs_q[word[19:15]];
		src2  = regs_q[word[24:20]];
		imm_i = {{20{word[31]}}, word[31:20]};
		imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
		imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
		res   = 32'd0;
		nxt   = pc_q + 32'd4;
		wr    = 1'b0;
		ill   = 1'b0;
		tk    = 1'b0;
		case (op)
			7'b0110111: begin
				res = {word[31:12], 12'd0};
				wr  = 1'b1;
			end
			7'b0010111: begin
				res = pc_q + {word[31:12], 12'd0};
				wr  = 1'b1;
			end
			7'b1101111: begin
				// Link value is the fall-through address
				res = pc_q + 32'd4;
				wr  = 1'b1;
				nxt = pc_q + imm_j;
			end
			7'b1100011: begin
				case (f3)
					3'd0:    tk = (src1 == src2);
					3'd1:    tk = (src1 != src2);
					3'd4:    tk = ($signed(src1) < $signed(src2));
					3'd5:    tk = ($signed(src1) >= $signed(src2));
					3'd6:    tk = (src1 < src2);
					3'd7:    tk = (src1 >= src2);
					default: ill = 1'b1;
				endcase
				if (tk)
					nxt = pc_q + imm_b;
			end
			7'b0010011: begin
				wr  = 1'b1;
				res = alu_ref(f3, (f3 == 3'd5) && (f7 == 7'h20), src1, imm_i);
				// Shift-immediates only allow the two standard upper fields
				if (f3 == 3'd1)
					ill = (f7 != 7'h00);
				else if (f3 == 3'd5)
					ill = (f7 != 7'h00) && (f7 != 7'h20);
			end
			7'b0110011: begin
				wr  = 1'b1;
				res = alu_ref(f3, f7 == 7'h20, src1, src2);
				ill = !((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5))));
			end
			default: ill = 1'b1;
		endcase
		if (ill)
			wr = 1'b0;
		exp_o.valid   = 1'b1;
		exp_o.pc      = pc_q;
		exp_o.illegal = ill;
		// Nothing written reports as rd zero with zero data
		exp_o.rd      = (wr && (rd != 5'd0)) ? rd : 5'd0;
		exp_o.wdata   = (wr && (rd != 5'd0)) ? res : 32'd0;
	end

	// Advance once per DUT retire
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= `RV_RESET_VECTOR;
			for (int k = 0; k < `RV_NREGS; k++)
				regs_q[k[4:0]] <= 32'd0;
		end else if (step_i) begin
			pc_q <= nxt;
			if (exp_o.rd != 5'd0)
				regs_q[exp_o.rd] <= exp_o.wdata;
		end
	end

endmodule

`default_nettype wire

// ==== dv/rv_tb.sv ====
// ==================================================
// Testbench for the RV32I pipeline core
// Random program image, APB slave with wait states,
// retire checks against the reference model,
// APB protocol checks and a cycle timeout
// ==================================================

`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module rv_tb import rv_pkg::*; ();

	localparam int NWORDS         = 1 << (`RV_IMEM_AW - 2);
	localparam int N_RETIRE       = 2000;
	localparam int TIMEOUT_CYCLES = N_RETIRE * 6;

	logic        clk;
	logic        rst_n;
	logic [31:0] paddr;
	logic        psel;
	logic        penable;
	logic [31:0] prdata = 32'd0;
	logic        pready = 1'b0;
	retire_t     retire;
	retire_t     exp_rec;
	logic [31:0] imem [0:NWORDS-1];
	integer      seed;
	int          n_retired;
	int          cycles;
	int          err_cnt;
	int          wait_left;
	logic        prev_psel;
	logic        prev_penable;
	logic        prev_pready;
	logic [31:0] prev_paddr;
	logic        seen_first;

	rv_core_top uut (
		.clk(clk), .rst_n(rst_n),
		.paddr_o(paddr), .psel_o(psel), .penable_o(penable),
		.prdata_i(prdata), .pready_i(pready), .retire_o(retire)
	);

	// Model steps on every valid retire record
	rv_ref_model ref_m (
		.clk(clk), .rst_n(rst_n), .step_i(retire.valid), .mem_i(imem), .exp_o(exp_rec)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ==================================================
	// Program image
	// ==================================================
	function automatic logic [31:0] enc_branch(input logic [31:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		enc_branch = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_jal(input logic [31:0] off, input logic [4:0] rd);
		enc_jal = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	task automatic build_program;
		logic [31:0] r;
		logic [31:0] off;
		logic [6:0]  f7;
		logic [2:0]  f3;
		int          kind;
		for (int k = 0; k < NWORDS; k++) begin
			r    = $random(seed);
			kind = $unsigned($random(seed)) % 100;
			f3   = r[14:12];
			if (kind < 5) begin
				// Load opcode, not supported
				imem[k[`RV_IMEM_AW-3:0]] = {r[31:7], 7'b0000011};
			end else if (kind < 13) begin
				imem[k[`RV_IMEM_AW-3:0]] = {r[31:12], r[11:7], 7'b0110111};
			end else if (kind < 18) begin
				imem[k[`RV_IMEM_AW-3:0]] = {r[31:12], r[11:7], 7'b0010111};
			end else if (kind < 25) begin
				off = ($unsigned($random(seed)) % 128 - 64) * 4;
				if (off == 32'd0)
					off = 32'd4;
				imem[k[`RV_IMEM_AW-3:0]] = enc_jal(off, r[11:7]);
			end else if (kind < 50) begin
				// Map the two reserved funct3 codes onto BLTU and BGEU
				if (f3[2:1] == 2'b01)
					f3 = f3 | 3'b100;
				off = ($unsigned($random(seed)) % 32 - 16) * 4;
				if (off == 32'd0)
					off = 32'd4;
				imem[k[`RV_IMEM_AW-3:0]] = enc_branch(off, r[24:20], r[19:15], f3);
			end else if (kind < 80) begin
				f7 = r[31:25];
				if (f3 == 3'd1)
					f7 = 7'h00;
				else if (f3 == 3'd5)
					f7 = r[30] ? 7'h20 : 7'h00;
				imem[k[`RV_IMEM_AW-3:0]] = {f7, r[24:20], r[19:15], f3, r[11:7], 7'b0010011};
			end else begin
				f7 = (((f3 == 3'd0) || (f3 == 3'd5)) && r[30]) ? 7'h20 : 7'h00;
				imem[k[`RV_IMEM_AW-3:0]] = {f7, r[24:20], r[19:15], f3, r[11:7], 7'b0110011};
			end
		end
	endtask

	// ==================================================
	// Error reporting and end of run
	// ==================================================
	task automatic abort_run;
		err_cnt++;
		$display("** FAIL **");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic report_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
		abort_run();
	endtask

	task automatic report_fault(input string msg);
		$display("Error at %0t: %s", $time, msg);
		abort_run();
	endtask

	task automatic check_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else report_value(name, got, exp);
	endtask

	task automatic finish_run;
		if (err_cnt == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			abort_run();
		end
	endtask

	// Stimulus start and reset
	initial begin
		seed         = 55148;
		rst_n        = 1'b0;
		n_retired    = 0;
		cycles       = 0;
		err_cnt      = 0;
		wait_left    = 0;
		seen_first   = 1'b0;
		build_program();
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
	end

	// ==================================================
	// APB slave, 0 to 3 wait states per transfer
	// ==================================================
	always @(posedge clk) begin : apb_slave
		int w;
		if (!rst_n) begin
			pready <= 1'b0;
		end else if (psel && !penable) begin
			w = $unsigned($random(seed)) % 4;
			wait_left <= w;
			pready    <= (w == 0);
			prdata    <= imem[paddr[`RV_IMEM_AW-1:2]];
		end else if (psel && penable) begin
			if (pready)
				pready <= 1'b0;
			else if (wait_left == 1)
				pready <= 1'b1;
			if (!pready)
				wait_left <= wait_left - 1;
		end
	end

	// Protocol, retire and timeout checks on values from the closing cycle
	always @(posedge clk) begin : monitor
		if (!rst_n) begin
			prev_psel    = 1'b0;
			prev_penable = 1'b0;
			prev_pready  = 1'b0;
			prev_paddr   = 32'd0;
		end else begin
			cycles++;
			assert (cycles <= TIMEOUT_CYCLES)
			else report_fault($sformatf("timeout after %0d cycles, only %0d retired",
				cycles, n_retired));
			if (psel && !seen_first) begin
				seen_first = 1'b1;
				check_word("paddr_o", paddr, `RV_RESET_VECTOR);
			end
			if (penable) begin
				assert (prev_psel && (!prev_penable || !prev_pready))
				else report_fault("penable_o raised without a setup cycle before it");
			end
			if (prev_psel && !prev_penable) begin
				assert (penable) else report_fault("setup cycle not followed by access");
			end
			// Open transfer holds select and address
			if (prev_psel && !(prev_penable && prev_pready)) begin
				assert (psel) else report_fault("psel_o dropped before pready_i");
				check_word("paddr_o", paddr, prev_paddr);
			end
			prev_psel    = psel;
			prev_penable = penable;
			prev_pready  = pready;
			prev_paddr   = paddr;
			if (retire.valid) begin
				check_word("retire_o.pc", retire.pc, exp_rec.pc);
				check_word("retire_o.illegal", {31'd0, retire.illegal},
					{31'd0, exp_rec.illegal});
				check_word("retire_o.rd", {27'd0, retire.rd}, {27'd0, exp_rec.rd});
				check_word("retire_o.wdata", retire.wdata, exp_rec.wdata);
				n_retired++;
			end
			if (n_retired == N_RETIRE)
				finish_run();
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the core testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -j 0 -f tb.f --top-module rv_tb \
		-Mdir obj_dir -o rv_sim &&
	./obj_dir/rv_sim | tee /dev/stderr | grep -q '^\*\* PASS \*\*$' &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }

// ==== src/rv_core_top.sv ====
// ==================================================
// Core top level
// Fetch, decode, execute and register file,
// APB fetch master and retire trace
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module rv_core_top import rv_pkg::*; (
	input  wire         clk,
	input  wire         rst_n,
	// Read-only APB port, so no write strobe leaves the core
	output logic [31:0] paddr_o,
	output logic        psel_o,
	output logic        penable_o,
	input  wire [31:0]  prdata_i,
	input  wire         pready_i,
	output retire_t     retire_o
);

	fd_t         fd;
	dx_t         dx;
	logic        take;
	redirect_t   dec_redirect;
	redirect_t   exec_redirect;
	logic [4:0]  rf_rs1;
	logic [4:0]  rf_rs2;
	logic [4:0]  rf_rd;
	logic        rf_wen;
	logic [31:0] rf_wdata;
	logic [31:0] rf_rdata1;
	logic [31:0] rf_rdata2;

	rv_fetch u_fetch (
		.clk(clk), .rst_n(rst_n),
		.redirect_i(dec_redirect), .exec_redirect_i(exec_redirect),
		.take_i(take), .fd_o(fd),
		.paddr_o(paddr_o), .psel_o(psel_o), .penable_o(penable_o),
		.prdata_i(prdata_i), .pready_i(pready_i)
	);

	// Execute redirect also squashes whatever decode holds
	rv_decode u_decode (
		.clk(clk), .rst_n(rst_n), .fd_i(fd), .flush_i(exec_redirect.valid),
		.take_o(take), .redirect_o(dec_redirect), .dx_o(dx)
	);

	rv_execute u_execute (
		.clk(clk), .rst_n(rst_n), .dx_i(dx),
		.rs1_o(rf_rs1), .rs2_o(rf_rs2), .rd_o(rf_rd), .wen_o(rf_wen), .wdata_o(rf_wdata),
		.rdata1_i(rf_rdata1), .rdata2_i(rf_rdata2),
		.redirect_o(exec_redirect), .retire_o(retire_o)
	);

	rv_regfile u_regfile (
		.clk(clk), .rst_n(rst_n), .rs1_i(rf_rs1), .rs2_i(rf_rs2), .rd_i(rf_rd),
		.wen_i(rf_wen), .wdata_i(rf_wdata), .rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2)
	);

endmodule

`default_nettype wire

// ==== src/rv_decode.sv ====
// ==================================================
// Instruction decode stage
// Immediates, execute controls, static prediction
// and the decode/execute pipeline register
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module rv_decode import rv_pkg::*; (
	input  wire        clk,
	input  wire        rst_n,
	input  wire fd_t   fd_i,
	input  wire        flush_i,
	output logic       take_o,
	output redirect_t  redirect_o,
	output dx_t        dx_o
);

	rv_instr_u   ins;
	logic        d_valid;
	logic [2:0]  f3;
	logic [6:0]  f7;
	logic [31:0] imm_i;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	logic [31:0] jump_offs;
	dx_t         d_dx;
	dx_t         dx_q;

	// Shared funct3 mapping of the two ALU groups
	function automatic alu_op_e alu_of(input logic [2:0] fn, input logic alt);
		case (fn)
			3'b000:  alu_of = alt ? ALU_SUB : ALU_ADD;
			3'b001:  alu_of = ALU_SLL;
			3'b010:  alu_of = ALU_SLT;
			3'b011:  alu_of = ALU_SLTU;
			3'b100:  alu_of = ALU_XOR;
			3'b101:  alu_of = alt ? ALU_SRA : ALU_SRL;
			3'b110:  alu_of = ALU_OR;
			default: alu_of = ALU_AND;
		endcase
	endfunction

	assign ins     = fd_i.instr;
	assign f3      = ins.r.funct3;
	assign f7      = ins.r.funct7;
	// Flushed slot is dropped here and becomes a bubble
	assign d_valid = fd_i.valid && !flush_i;

	// ==================================================
	// Immediate extraction
	// ==================================================
	assign imm_i = {{20{ins.i.imm[11]}}, ins.i.imm};
	assign imm_b = {{19{ins.b.imm12}}, ins.b.imm12, ins.b.imm11, ins.b.imm10_5,
		ins.b.imm4_1, 1'b0};
	assign imm_u = {ins.u.imm, 12'b0};
	assign imm_j = {{11{ins.j.imm20}}, ins.j.imm20, ins.j.imm19_12, ins.j.imm11,
		ins.j.imm10_1, 1'b0};

	// ==================================================
	// Control decode
	// ==================================================
	always_comb begin
		jump_offs            = imm_b;
		d_dx.valid           = d_valid;
		d_dx.illegal         = 1'b0;
		d_dx.pc              = fd_i.pc;
		// Register fields sit at the same place in every format that has them
		d_dx.rs1             = ins.s.rs1;
		d_dx.rs2             = ins.s.rs2;
		d_dx.rd              = ins.r.rd;
		d_dx.imm             = imm_i;
		d_dx.alusrc_a        = SRCA_RS1;
		d_dx.alusrc_b        = SRCB_RS2;
		d_dx.aluop           = ALU_ADD;
		d_dx.branchcond      = BC_NEVER;
		d_dx.pc_next         = fd_i.pc + 32'd4;
		case (ins.r.opcode)
			OP_LUI: begin
				d_dx.imm      = imm_u;
				d_dx.alusrc_a = SRCA_ZERO;
				d_dx.alusrc_b = SRCB_IMM;
				d_dx.rs1      = 5'd0;
				d_dx.rs2      = 5'd0;
			end
			OP_AUIPC: begin
				d_dx.imm      = imm_u;
				d_dx.alusrc_a = SRCA_PC;
				d_dx.alusrc_b = SRCB_IMM;
				d_dx.rs1      = 5'd0;
				d_dx.rs2      = 5'd0;
			end
			OP_JAL: begin
				jump_offs       = imm_j;
				d_dx.branchcond = BC_ALWAYS;
				d_dx.rs1        = 5'd0;
				d_dx.rs2        = 5'd0;
			end
			OP_BRANCH: begin
				d_dx.rd    = 5'd0;
				// SUB for equality, compares for the rest
				d_dx.aluop = f3[2] ? (f3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
				d_dx.branchcond = (f3[0] ^ f3[2]) ? BC_NZERO : BC_ZERO;
				d_dx.illegal    = (f3[2:1] == 2'b01);
			end
			OP_IMM: begin
				d_dx.alusrc_b = SRCB_IMM;
				d_dx.rs2      = 5'd0;
				d_dx.aluop    = alu_of(f3, (f3 == 3'b101) && f7[5]);
				if (f3 == 3'b001)
					d_dx.illegal = (f7 != 7'h00);
				else if (f3 == 3'b101)
					d_dx.illegal = (f7 != 7'h00) && (f7 != 7'h20);
			end
			OP_REG: begin
				d_dx.aluop   = alu_of(f3, f7[5]);
				d_dx.illegal = !((f7 == 7'h00) ||
					((f7 == 7'h20) && ((f3 == 3'b000) || (f3 == 3'b101))));
			end
			default: d_dx.illegal = 1'b1;
		endcase
		d_dx.target = fd_i.pc + jump_offs;
		if (d_dx.illegal || !d_valid) begin
			d_dx.rd         = 5'd0;
			d_dx.branchcond = BC_NEVER;
		end
		if (!d_valid) begin
			d_dx.illegal = 1'b0;
			d_dx.rs1     = 5'd0;
			d_dx.rs2     = 5'd0;
		end
		// JAL always, conditional branches only backwards
		d_dx.predicted_taken = (d_dx.branchcond == BC_ALWAYS) ||
			((d_dx.branchcond != BC_NEVER) && jump_offs[31]);
	end

	// Decode/execute register, a bubble when nothing was taken
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			dx_q <= '0;
		else
			dx_q <= d_dx;
	end

	assign take_o            = fd_i.valid;
	assign redirect_o.valid  = d_dx.predicted_taken;
	assign redirect_o.target = d_dx.target;
	assign dx_o              = dx_q;

endmodule

`default_nettype wire

// ==== src/rv_execute.sv ====
// ==================================================
// Execute stage
// Operand select, ALU, branch resolution,
// mispredict redirect, write-back and retire trace
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module rv_execute import rv_pkg::*; (
	input  wire         clk,
	input  wire         rst_n,
	input  wire dx_t    dx_i,
	output logic [4:0]  rs1_o,
	output logic [4:0]  rs2_o,
	output logic [4:0]  rd_o,
	output logic        wen_o,
	output logic [31:0] wdata_o,
	input  wire [31:0]  rdata1_i,
	input  wire [31:0]  rdata2_i,
	output redirect_t   redirect_o,
	output retire_t     retire_o
);

	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] alu_res;
	logic        alu_zero;
	logic        taken;
	logic        wen;
	logic [31:0] wdata;
	retire_t     retire_q;

	// Register file is addressed straight from the pipeline register
	assign rs1_o = dx_i.rs1;
	assign rs2_o = dx_i.rs2;

	// ==================================================
	// Operands and ALU
	// ==================================================
	always_comb begin
		case (dx_i.alusrc_a)
			SRCA_PC:   op_a = dx_i.pc;
			SRCA_ZERO: op_a = 32'd0;
			default:   op_a = rdata1_i;
		endcase
		op_b = (dx_i.alusrc_b == SRCB_IMM) ? dx_i.imm : rdata2_i;
	end

	always_comb begin
		case (dx_i.aluop)
			ALU_SUB:  alu_res = op_a - op_b;
			ALU_SLL:  alu_res = op_a << op_b[4:0];
			ALU_SLT:  alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_res = {31'd0, op_a < op_b};
			ALU_XOR:  alu_res = op_a ^ op_b;
			ALU_SRL:  alu_res = op_a >> op_b[4:0];
			ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
			ALU_OR:   alu_res = op_a | op_b;
			ALU_AND:  alu_res = op_a & op_b;
			default:  alu_res = op_a + op_b;
		endcase
	end

	assign alu_zero = (alu_res == 32'd0);

	// ==================================================
	// Branch resolution
	// ==================================================
	always_comb begin
		case (dx_i.branchcond)
			BC_ALWAYS: taken = 1'b1;
			BC_ZERO:   taken = alu_zero;
			BC_NZERO:  taken = !alu_zero;
			default:   taken = 1'b0;
		endcase
	end

	// Fix up a wrong guess from decode
	assign redirect_o.valid  = dx_i.valid && (taken != dx_i.predicted_taken);
	assign redirect_o.target = taken ? dx_i.target : dx_i.pc_next;

	// Only JAL uses the always condition and it links pc + 4
	assign wen   = dx_i.valid && !dx_i.illegal && (dx_i.rd != 5'd0);
	assign wdata = (dx_i.branchcond == BC_ALWAYS) ? dx_i.pc_next : alu_res;

	assign rd_o    = dx_i.rd;
	assign wen_o   = wen;
	assign wdata_o = wdata;

	// Retire record, registered alongside the write-back edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			retire_q <= '0;
		end else begin
			retire_q.valid   <= dx_i.valid;
			retire_q.pc      <= dx_i.pc;
			retire_q.illegal <= dx_i.illegal;
			retire_q.rd      <= wen ? dx_i.rd : 5'd0;
			retire_q.wdata   <= wen ? wdata : 32'd0;
		end
	end

	assign retire_o = retire_q;

endmodule

`default_nettype wire

// ==== src/rv_fetch.sv ====
// ==================================================
// Instruction fetch stage
// APB read master, fetch PC, one-entry buffer
// and redirect handling with stale-data discard
// ==================================================

`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module rv_fetch import rv_pkg::*; (
	input  wire            clk,
	input  wire            rst_n,
	input  wire redirect_t redirect_i,
	input  wire redirect_t exec_redirect_i,
	input  wire            take_i,
	output fd_t            fd_o,
	output logic [31:0]    paddr_o,
	output logic           psel_o,
	output logic           penable_o,
	input  wire [31:0]     prdata_i,
	input  wire            pready_i
);

	typedef enum logic [1:0] {PH_IDLE, PH_SETUP, PH_ACCESS} phase_e;

	phase_e      phase_q;
	logic [31:0] pc_q;
	logic [31:0] paddr_q;
	logic        discard_q;
	fd_t         buf_q;
	redirect_t   redir;
	logic        xfer_done;
	logic        launch;
	logic [31:0] launch_addr;

	// Execute wins over decode
	assign redir = exec_redirect_i.valid ? exec_redirect_i : redirect_i;

	assign xfer_done = (phase_q == PH_ACCESS) && pready_i;
	// Chain straight into the next setup when a word lands
	// Decode never stalls, so the buffer drains before that word returns
	assign launch = xfer_done || ((phase_q == PH_IDLE) && (!buf_q.valid || take_i));
	assign launch_addr = redir.valid ? redir.target : pc_q;

	// ==================================================
	// APB phase, address and PC
	// ==================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase_q   <= PH_IDLE;
			pc_q      <= `RV_RESET_VECTOR;
			paddr_q   <= `RV_RESET_VECTOR;
			discard_q <= 1'b0;
		end else begin
			case (phase_q)
				PH_IDLE:   if (launch) phase_q <= PH_SETUP;
				PH_SETUP:  phase_q <= PH_ACCESS;
				PH_ACCESS: if (pready_i) phase_q <= PH_SETUP;
				default:   phase_q <= PH_IDLE;
			endcase
			// Address held for the whole transfer
			if (launch) begin
				paddr_q <= launch_addr;
				pc_q    <= launch_addr + 32'd4;
			end else if (redir.valid) begin
				pc_q <= redir.target;
			end
			// Transfer still open after a redirect returns stale data
			if (xfer_done)
				discard_q <= 1'b0;
			else if (redir.valid && (phase_q != PH_IDLE))
				discard_q <= 1'b1;
		end
	end

	// One-entry buffer in front of decode
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_q <= '0;
		end else if (redir.valid) begin
			buf_q.valid <= 1'b0;
		end else if (xfer_done && !discard_q) begin
			buf_q.valid <= 1'b1;
			buf_q.pc    <= paddr_q;
			buf_q.instr <= prdata_i;
		end else if (take_i) begin
			buf_q.valid <= 1'b0;
		end
	end

	assign fd_o      = buf_q;
	assign paddr_o   = paddr_q;
	assign psel_o    = (phase_q != PH_IDLE);
	assign penable_o = (phase_q == PH_ACCESS);

endmodule

`default_nettype wire

// ==== src/rv_params.svh ====
// ==================================================
// Core-wide constants for the RV32I pipeline
// Reset vector, instruction memory decode width
// and size of the integer register file
// ==================================================

`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Address of the first instruction fetched after reset
`define RV_RESET_VECTOR 32'h0000_0000

// Low address bits decoded by the instruction memory, 256 words
`define RV_IMEM_AW 10

// Architectural integer registers, x0 included
`define RV_NREGS 32

`endif

// ==== src/rv_pkg.sv ====
// ==================================================
// Shared types for the RV32I pipeline
// Major opcodes, ALU and branch encodings,
// instruction word views and stage records
// ==================================================

`default_nettype none

package rv_pkg;

	// Major opcodes of the supported groups
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_e;

	// Branch taken test on the ALU result
	typedef enum logic [1:0] {BC_NEVER, BC_ALWAYS, BC_ZERO, BC_NZERO} bcond_e;

	typedef enum logic [1:0] {SRCA_RS1, SRCA_PC, SRCA_ZERO} alusrc_a_e;
	typedef enum logic {SRCB_RS2, SRCB_IMM} alusrc_b_e;

	// ==================================================
	// Instruction formats, msb first
	// ==================================================
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	// Branch offset bits are scattered over the word
	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t      r;
		i_fmt_t      i;
		s_fmt_t      s;
		b_fmt_t      b;
		u_fmt_t      u;
		j_fmt_t      j;
		logic [31:0] raw;
	} rv_instr_u;

	// ==================================================
	// Stage records
	// ==================================================
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		rv_instr_u   instr;
	} fd_t;

	typedef struct packed {
		logic        valid;
		logic        illegal;
		logic [31:0] pc;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic [31:0] imm;
		alusrc_a_e   alusrc_a;
		alusrc_b_e   alusrc_b;
		alu_op_e     aluop;
		bcond_e      branchcond;
		logic        predicted_taken;
		logic [31:0] target;
		logic [31:0] pc_next;
	} dx_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] target;
	} redirect_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic        illegal;
		logic [4:0]  rd;
		logic [31:0] wdata;
	} retire_t;

endpackage

`default_nettype wire

// ==== src/rv_regfile.sv ====
// ==================================================
// Integer register file
// x0 reads as zero, two async reads, one write
// ==================================================

`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module rv_regfile (
	input  wire        clk,
	input  wire        rst_n,
	input  wire [4:0]  rs1_i,
	input  wire [4:0]  rs2_i,
	input  wire [4:0]  rd_i,
	input  wire        wen_i,
	input  wire [31:0] wdata_i,
	output logic [31:0] rdata1_o,
	output logic [31:0] rdata2_o
);

	// No storage behind x0
	logic [31:0] regs_q [1:`RV_NREGS-1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 1; k < `RV_NREGS; k++)
				regs_q[k] <= '0;
		end else if (wen_i && (rd_i != 5'd0)) begin
			regs_q[rd_i] <= wdata_i;
		end
	end

	// Reads see the value written at the end of the previous execute
	assign rdata1_o = (rs1_i == 5'd0) ? 32'd0 : regs_q[rs1_i];
	assign rdata2_o = (rs2_i == 5'd0) ? 32'd0 : regs_q[rs2_i];

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+src
src/rv_pkg.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_core_top.sv
dv/rv_ref_model.sv
dv/rv_tb.sv
